//--- hw/uart_defs.svh
/*
 * UART shared constants
 * serial word format, oversampling stop length, FIFO depth
 * and the register map of the byte-wide processor port
 */
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// serial frame

`define dataBits        8       // bits per serial word
`define sbTick          16      // ticks in one stop bit

//////////////////////////////////////////////////////////////////////
// buffering and register map

`define fifoDepth       16      // entries per direction

`define regAddrLen      2
`define regAddrData     `regAddrLen'd0  // tx push / rx pop
`define regAddrCtrl     `regAddrLen'd1  // enables and baud divisor
`define regAddrStat     `regAddrLen'd2  // flags, read clears errors

`endif

//--- hw/uartPkg.sv
/*
 * UART types
 * control word, status word, the register data word seen three ways
 * and the receive event handed from the receiver to the register block
 */
`include "uart_defs.svh"

package uartPkg;

	// control register, loaded by a CTRL write
	typedef struct packed {
		logic       txEn;       // transmitter may start a frame
		logic       rxEn;       // receiver may accept a start bit
		logic [5:0] divisor;    // tick every divisor+1 clocks
	} uartCtrl_t;

	// status register
	typedef struct packed {
		logic txFull;
		logic txEmpty;
		logic rxFull;
		logic rxEmpty;
		logic txBusy;
		logic overrun;          // sticky, rx byte lost on full fifo
		logic frameErr;         // sticky, stop bit sampled low
		logic rsvd;             // reads zero
	} uartStat_t;

	// one register word, meaning picked by the address
	typedef union packed {
		logic [`dataBits-1:0] data;
		uartCtrl_t            ctrl;
		uartStat_t            stat;
	} regWord_u;

	// received byte with its completion pulse
	typedef struct packed {
		logic [`dataBits-1:0] data;
		logic                 done;     // one clk wide
		logic                 stopErr;  // valid with done
	} rxEvent_t;

endpackage

//--- hw/baudTickGen.sv
/*
 * Baud tick generator
 * divides clk by divisor+1 into a one-cycle 16x oversampling tick,
 * idle while both serial directions are disabled
 */
`timescale 1ns/10ps

module baudTickGen (
	input  logic               clk,
	input  logic               reset,
	input  uartPkg::uartCtrl_t ctrl,
	output logic               sTick
);

	localparam int cntW = $bits(ctrl.divisor);

	logic [cntW-1:0] cnt;           // down counter
	logic            running;

	assign running = ctrl.txEn | ctrl.rxEn;

	//////////////////////////////////////////////////////////////////////
	// counter and tick

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt   <= '0;
			sTick <= 1'b0;
		end
		else if (!running)
		begin
			cnt   <= ctrl.divisor;      // parked at reload
			sTick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt   <= ctrl.divisor;      // new divisor picked up here
			sTick <= 1'b1;
		end
		else
		begin
			cnt   <= cnt - 1'b1;
			sTick <= 1'b0;
		end
	end

endmodule

//--- hw/uartFifo.sv
/*
 * Show-ahead FIFO
 * circular buffer with occupancy count, head always on dout
 * full/empty flags, push on full and pop on empty are ignored
 */
`timescale 1ns/10ps
`include "uart_defs.svh"

module uartFifo #(
	parameter int depth = `fifoDepth
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 push,
	input  logic                 pop,
	input  logic [`dataBits-1:0] din,
	output logic [`dataBits-1:0] dout,
	output logic                 full,
	output logic                 empty
);

	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);

	logic [`dataBits-1:0] mem [depth];
	logic [ptrW-1:0]      wrPtr, rdPtr;
	logic [cntW-1:0]      count;     // entries held
	logic                 doPush, doPop;

	assign full   = (count == cntW'(depth));
	assign empty  = (count == '0);
	assign doPush = push & ~full;
	assign doPop  = pop & ~empty;
	assign dout   = mem[rdPtr];     // show-ahead head

	// storage, no reset
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= din;
	end

	//////////////////////////////////////////////////////////////////////
	// pointers and count

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // none, or push and pop together
			endcase
		end
	end

endmodule

//--- hw/uartTrans.sv
/*
 * UART transmitter
 * four-state FSM (idle, start, data, stop) paced by the 16x tick
 * 8 data bits LSB first and one stop bit, pops the tx FIFO on leaving idle
 */
`timescale 1ns/10ps
`include "uart_defs.svh"

module uartTrans (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 sTick,
	input  logic                 txStart,
	input  logic [`dataBits-1:0] din,
	output logic                 tx,
	output logic                 txDoneTick,
	output logic                 txBusy
);

	localparam logic [3:0] bitLast = 4'd15;     // 16 ticks per bit

	typedef enum logic [1:0] {idle, start, data, stop} txState_t;

	txState_t                      stateReg, stateNext;
	logic [3:0]                    sReg, sNext;     // tick counter
	logic [$clog2(`dataBits)-1:0]  nReg, nNext;     // bit counter
	logic [`dataBits-1:0]          bReg, bNext;     // shift register
	logic                          txReg, txNext;

	//////////////////////////////////////////////////////////////////////
	// state registers

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			bReg     <= '0;
			txReg    <= 1'b1;   // line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			bReg     <= bNext;
			txReg    <= txNext;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txDoneTick = 1'b0;
		case (stateReg)
			idle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;      // fifo pop
					bNext      = din;       // head still valid on this edge
					sNext      = '0;
					stateNext  = start;
				end
			end
			start:
			begin
				txNext = 1'b0;              // start bit
				if (sTick)
				begin
					if (sReg == bitLast)
					begin
						sNext     = '0;
						nNext     = '0;
						stateNext = data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			data:
			begin
				txNext = bReg[0];           // lsb first
				if (sTick)
				begin
					if (sReg == bitLast)
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == $clog2(`dataBits)'(`dataBits - 1))
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			stop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == 4'(`sbTick - 1))
						stateNext = idle;   // done was already signalled at start
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = idle;
		endcase
	end

	assign tx     = txReg;
	assign txBusy = (stateReg != idle);

endmodule

//--- hw/uartRecv.sv
/*
 * UART receiver
 * 16x oversampling, start bit confirmed at its middle,
 * data and stop sampled every 16th tick, stop-bit check and done pulse
 */
`timescale 1ns/10ps
`include "uart_defs.svh"

module uartRecv (
	input  logic                clk,
	input  logic                reset,
	input  logic                sTick,
	input  logic                rxEn,
	input  logic                rx,
	output uartPkg::rxEvent_t   rxEvent
);

	localparam logic [3:0] bitLast = 4'd15;
	localparam logic [3:0] midTick = 4'd7;     // 8th tick of the start bit

	typedef enum logic [1:0] {idle, start, data, stop} rxState_t;

	rxState_t                      stateReg, stateNext;
	logic [3:0]                    sReg, sNext;
	logic [$clog2(`dataBits)-1:0]  nReg, nNext;
	logic [`dataBits-1:0]          bReg, bNext;
	logic                          doneReg, doneNext;
	logic                          errReg, errNext;
	logic                          rxMeta, rxSync, rxPrev;
	logic                          rxFall;

	//////////////////////////////////////////////////////////////////////
	// synchronizer and edge detect

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxPrev <= rxSync;   // edge detect only
		end
	end

	assign rxFall = rxPrev & ~rxSync;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			doneReg  <= 1'b0;
			errReg   <= 1'b0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			doneReg  <= doneNext;
			errReg   <= errNext;
		end
	end

	// payload shift register
	always_ff @(posedge clk)
		bReg <= bNext;

	//////////////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		doneNext  = 1'b0;
		errNext   = 1'b0;
		case (stateReg)
			idle:
				if (rxEn && rxFall)
				begin
					sNext     = '0;
					stateNext = start;
				end
			start:
				if (sTick)
				begin
					if (sReg == midTick)
					begin
						sNext     = '0;
						nNext     = '0;
						stateNext = rxSync ? idle : data;   // glitch goes back
					end
					else
						sNext = sReg + 1'b1;
				end
			data:
				if (sTick)
				begin
					if (sReg == bitLast)
					begin
						sNext = '0;
						bNext = {rxSync, bReg[`dataBits-1:1]};  // lsb arrives first
						if (nReg == $clog2(`dataBits)'(`dataBits - 1))
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			stop:
				if (sTick)
				begin
					if (sReg == 4'(`sbTick - 1))
					begin
						doneNext  = 1'b1;       // mid stop bit
						errNext   = ~rxSync;
						stateNext = idle;
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = idle;
		endcase
	end

	assign rxEvent = '{data: bReg, done: doneReg, stopErr: errReg};

endmodule

//--- hw/uartRegs.sv
/*
 * UART register block
 * decodes the byte-wide register port, holds the control word and
 * the sticky error flags, builds status and registers the read data
 */
`timescale 1ns/10ps
`include "uart_defs.svh"

module uartRegs (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`regAddrLen-1:0] addr,
	input  logic                   wrEn,
	input  logic                   rdEn,
	input  uartPkg::regWord_u      wrData,
	output uartPkg::regWord_u      rdData,
	output uartPkg::uartCtrl_t     ctrl,
	output logic                   txPush,
	output logic [`dataBits-1:0]   txByte,
	output logic                   txReq,
	output logic                   rxPop,
	input  logic                   txFull,
	input  logic                   txEmpty,
	input  logic                   rxFull,
	input  logic                   rxEmpty,
	input  logic [`dataBits-1:0]   rxHead,
	input  logic                   txBusy,
	input  uartPkg::rxEvent_t      rxEvent,
	output logic                   rxPush
);

	uartPkg::uartStat_t stat;
	uartPkg::regWord_u  rdNext;
	logic               overrun, frameErr;
	logic               statRd, rxGood;

	//////////////////////////////////////////////////////////////////////
	// strobes to the datapath

	assign txPush = wrEn && (addr == `regAddrData) && !txFull;    // full drops the byte
	assign txByte = wrData.data;
	assign txReq  = ctrl.txEn & ~txEmpty;                          // tx start request
	assign rxPop  = rdEn && (addr == `regAddrData) && !rxEmpty;
	assign statRd = rdEn && (addr == `regAddrStat);

	assign rxGood = rxEvent.done & ~rxEvent.stopErr;
	assign rxPush = rxGood & ~rxFull;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ctrl <= '0;     // port disabled
		else if (wrEn && (addr == `regAddrCtrl))
			ctrl <= wrData.ctrl;
	end

	// sticky errors, a new event beats the clear
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			overrun  <= 1'b0;
			frameErr <= 1'b0;
		end
		else
		begin
			if (statRd)
			begin
				overrun  <= 1'b0;
				frameErr <= 1'b0;
			end
			if (rxGood && rxFull)
				overrun <= 1'b1;
			if (rxEvent.done && rxEvent.stopErr)
				frameErr <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// status word and read mux

	assign stat = '{txFull: txFull, txEmpty: txEmpty, rxFull: rxFull, rxEmpty: rxEmpty,
		txBusy: txBusy, overrun: overrun, frameErr: frameErr, rsvd: 1'b0};

	always_comb
	begin
		rdNext = '0;        // unmapped address reads zero
		case (addr)
			`regAddrData: rdNext.data = rxEmpty ? '0 : rxHead;
			`regAddrCtrl: rdNext.ctrl = ctrl;
			`regAddrStat: rdNext.stat = stat;
			default:      rdNext = '0;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rdData <= '0;
		else if (rdEn)
			rdData <= rdNext;   // held until the next read
	end

endmodule

//--- hw/uartTop.sv
/*
 * UART top level
 * register block, one FIFO per direction, baud tick generator
 * and the serial transmitter and receiver
 */
`timescale 1ns/10ps
`include "uart_defs.svh"

module uartTop (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`regAddrLen-1:0] addr,
	input  logic                   wrEn,
	input  logic                   rdEn,
	input  uartPkg::regWord_u      wrData,
	output uartPkg::regWord_u      rdData,
	output logic                   tx,
	input  logic                   rx
);

	uartPkg::uartCtrl_t   ctrl;
	uartPkg::rxEvent_t    rxEvent;
	logic                 sTick;
	logic                 txPush, txReq, txDoneTick, txBusy, txFull, txEmpty;
	logic                 rxPush, rxPop, rxFull, rxEmpty;
	logic [`dataBits-1:0] txByte, txHead, rxHead;

	uartRegs regs (
		.clk(clk), .reset(reset), .addr(addr), .wrEn(wrEn), .rdEn(rdEn),
		.wrData(wrData), .rdData(rdData), .ctrl(ctrl),
		.txPush(txPush), .txByte(txByte), .txReq(txReq), .rxPop(rxPop),
		.txFull(txFull), .txEmpty(txEmpty), .rxFull(rxFull), .rxEmpty(rxEmpty),
		.rxHead(rxHead), .txBusy(txBusy), .rxEvent(rxEvent), .rxPush(rxPush)
	);

	baudTickGen tickGen (.clk(clk), .reset(reset), .ctrl(ctrl), .sTick(sTick));

	//////////////////////////////////////////////////////////////////////
	// transmit path

	uartFifo #(.depth(`fifoDepth)) txFifo (
		.clk(clk), .reset(reset), .push(txPush), .pop(txDoneTick),
		.din(txByte), .dout(txHead), .full(txFull), .empty(txEmpty)
	);

	uartTrans trans (
		.clk(clk), .reset(reset), .sTick(sTick), .txStart(txReq), .din(txHead),
		.tx(tx), .txDoneTick(txDoneTick), .txBusy(txBusy)
	);

	//////////////////////////////////////////////////////////////////////
	// receive path

	uartRecv recv (
		.clk(clk), .reset(reset), .sTick(sTick), .rxEn(ctrl.rxEn), .rx(rx),
		.rxEvent(rxEvent)
	);

	uartFifo #(.depth(`fifoDepth)) rxFifo (
		.clk(clk), .reset(reset), .push(rxPush), .pop(rxPop),
		.din(rxEvent.data), .dout(rxHead), .full(rxFull), .empty(rxEmpty)
	);

endmodule

//--- verif/uart_checker.sv
/*
 * UART protocol checker
 * concurrent assertions on the top-level ports, bound into uartTop
 * reset level, strobe exclusion, tx low time and read data hold
 */
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_checker (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tx,
	input  logic                 wrEn,
	input  logic                 rdEn,
	input  logic [`dataBits-1:0] rdData,
	input  logic [5:0]           divisor
);

	int          failCount = 0;
	logic [15:0] lowCnt;        // clocks tx has been low
	logic [15:0] maxLow;

	// start + 8 data bits, plus one tick period of phase slack
	assign maxLow = 16'd144 * (16'(divisor) + 16'd1) + 16'(divisor) + 16'd2;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			lowCnt <= '0;
		else if (tx)
			lowCnt <= '0;
		else if (lowCnt != '1)
			lowCnt <= lowCnt + 1'b1;    // saturates
	end

	//////////////////////////////////////////////////////////////////////
	// assertions

	txIdleInReset: assert property (@(posedge clk) reset |-> tx)
	else
	begin
		failCount++;
		$error("tx was low while reset was active");
	end

	noWrAndRd: assert property (@(posedge clk) disable iff (reset) !(wrEn && rdEn))
	else
	begin
		failCount++;
		$error("write and read strobes were high in the same cycle");
	end

	txLowLimit: assert property (@(posedge clk) disable iff (reset) lowCnt <= maxLow)
	else
	begin
		failCount++;
		$error("tx stayed low for more than nine bit times");
	end

	rdDataHeld: assert property (@(posedge clk) disable iff (reset)
		!$stable(rdData) |-> $past(rdEn))
	else
	begin
		failCount++;
		$error("rdData changed without a read strobe in the cycle before");
	end

endmodule

//--- verif/uartTb.sv
/*
 * UART testbench
 * drives the register port on the falling edge, loops tx back to rx
 * or drives hand-built frames, checks with immediate assertions
 */
`timescale 1ns/10ps
`include "uart_defs.svh"

module uartTb;

	localparam int frameClocks = 320;                   // divisor 1, 160 ticks
	localparam int cycleLimit  = 60 * frameClocks + 2000;

	logic                   clk, reset;
	logic [`regAddrLen-1:0] addr;
	logic                   wrEn, rdEn;
	uartPkg::regWord_u      wrData, rdData;
	logic                   txLine, rxLine;
	logic                   rxSel;          // 1 = tb drives rx
	logic                   rxDrive;
	logic [31:0]            lfsr;
	logic [7:0]             sent [17];
	int                     errCount = 0;
	int                     cycles = 0;

	assign rxLine = rxSel ? rxDrive : txLine;   // external loopback

	uartTop DUT (.clk(clk), .reset(reset), .addr(addr), .wrEn(wrEn), .rdEn(rdEn),
		.wrData(wrData), .rdData(rdData), .tx(txLine), .rx(rxLine));

	bind uartTop uart_checker chk (.clk(clk), .reset(reset), .tx(tx), .wrEn(wrEn),
		.rdEn(rdEn), .rdData(rdData), .divisor(ctrl.divisor));

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("timeout, run still going after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'hD0000001;   // galois taps 32,31,29,1
		return n;
	endfunction

	task automatic nextByte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsrStep(lfsr);  // one step per bit
			b[i] = lfsr[0];
		end
	endtask

	task automatic checkVal(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
		else
		begin
			errCount++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		assert (act === exp)
		else
		begin
			errCount++;
			$display("** Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// all register tasks start and end on a falling edge
	task automatic writeReg(input logic [`regAddrLen-1:0] a, input uartPkg::regWord_u d);
		addr   = a;
		wrData = d;
		wrEn   = 1'b1;
		@(negedge clk);
		wrEn   = 1'b0;
	endtask

	task automatic writeByte(input logic [7:0] b);
		uartPkg::regWord_u w;
		w      = '0;
		w.data = b;
		writeReg(`regAddrData, w);
	endtask

	task automatic readReg(input logic [`regAddrLen-1:0] a, output uartPkg::regWord_u d);
		addr = a;
		rdEn = 1'b1;
		@(negedge clk);
		rdEn = 1'b0;
		d    = rdData;      // registered on the edge just passed
	endtask

	function automatic uartPkg::regWord_u ctrlWord(input logic txEn, input logic rxEn);
		uartPkg::regWord_u w;
		w              = '0;
		w.ctrl.txEn    = txEn;
		w.ctrl.rxEn    = rxEn;
		w.ctrl.divisor = 6'd1;      // tick every 2 clocks
		return w;
	endfunction

	// counts receiver done pulses
	task automatic waitRxFrames(input int n);
		int seen;
		seen = 0;
		while (seen < n)
		begin
			@(negedge clk);
			if (DUT.rxEvent.done)
				seen++;
		end
		@(negedge clk);     // fifo push and sticky flags land on this edge
	endtask

	task automatic pollTxIdle();
		uartPkg::regWord_u w;
		readReg(`regAddrStat, w);
		while (w.stat.txBusy || !w.stat.txEmpty)
			readReg(`regAddrStat, w);
	endtask

	// samples tx mid bit for one frame
	task automatic watchLine(input logic [7:0] expByte);
		logic [7:0] seen;
		@(negedge txLine);
		repeat (16) @(negedge clk);
		checkFlag("line start bit", 1'b0, txLine);
		for (int i = 0; i < 8; i++)
		begin
			repeat (32) @(negedge clk);
			seen[i] = txLine;   // lsb first
		end
		checkVal("line data bits", expByte, seen);
		repeat (32) @(negedge clk);
		checkFlag("line stop bit", 1'b1, txLine);
	endtask

	task automatic sendFrame(input logic [7:0] b, input logic stopBit);
		logic [9:0] bits;
		bits = {stopBit, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			rxDrive = bits[i];
			repeat (32) @(negedge clk);
		end
		rxDrive = 1'b1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests

	initial
	begin
		uartPkg::regWord_u  w;
		uartPkg::uartStat_t expStat;
		logic [7:0]         b;
		int                 chkFails;

		reset   = 1'b1;
		addr    = '0;
		wrEn    = 1'b0;
		rdEn    = 1'b0;
		wrData  = '0;
		rxSel   = 1'b0;
		rxDrive = 1'b1;     // idle line
		lfsr    = 32'h4460;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// reset state
		expStat         = '0;
		expStat.txEmpty = 1'b1;
		expStat.rxEmpty = 1'b1;
		readReg(`regAddrStat, w);
		checkVal("reset status", expStat, w.stat);
		readReg(`regAddrCtrl, w);
		checkVal("reset control", 8'h00, w.ctrl);

		// loopback of eight bytes, first frame watched on the line
		writeReg(`regAddrCtrl, ctrlWord(1'b1, 1'b1));
		for (int i = 0; i < 8; i++)
			nextByte(sent[i]);
		fork
			watchLine(sent[0]);
			begin
				for (int i = 0; i < 8; i++)
					writeByte(sent[i]);
				waitRxFrames(8);
			end
		join
		for (int i = 0; i < 8; i++)
		begin
			readReg(`regAddrData, w);
			checkVal("loopback byte", sent[i], w.data);
		end

		// tx fifo overflow with the transmitter held off
		writeReg(`regAddrCtrl, ctrlWord(1'b0, 1'b1));
		for (int i = 0; i < 17; i++)
		begin
			nextByte(sent[i]);
			writeByte(sent[i]);
		end
		readReg(`regAddrStat, w);
		checkFlag("tx overflow txFull", 1'b1, w.stat.txFull);
		checkFlag("tx overflow txEmpty", 1'b0, w.stat.txEmpty);
		writeReg(`regAddrCtrl, ctrlWord(1'b1, 1'b1));
		waitRxFrames(16);
		for (int i = 0; i < 16; i++)
		begin
			readReg(`regAddrData, w);
			checkVal("tx overflow byte", sent[i], w.data);
		end
		pollTxIdle();
		readReg(`regAddrData, w);
		checkVal("tx overflow no extra byte", 8'h00, w.data);
		readReg(`regAddrStat, w);
		checkFlag("tx overflow drained txEmpty", 1'b1, w.stat.txEmpty);
		checkFlag("tx overflow drained rxEmpty", 1'b1, w.stat.rxEmpty);

		// rx fifo overrun, 17 frames and no reads
		for (int i = 0; i < 17; i++)
		begin
			nextByte(sent[i]);
			writeByte(sent[i]);
		end
		waitRxFrames(17);
		readReg(`regAddrStat, w);
		checkFlag("overrun rxFull", 1'b1, w.stat.rxFull);
		checkFlag("overrun flag", 1'b1, w.stat.overrun);
		checkFlag("overrun frameErr", 1'b0, w.stat.frameErr);
		for (int i = 0; i < 16; i++)
		begin
			readReg(`regAddrData, w);
			checkVal("overrun byte", sent[i], w.data);
		end
		readReg(`regAddrStat, w);
		checkFlag("overrun cleared", 1'b0, w.stat.overrun);
		checkFlag("overrun rxEmpty", 1'b1, w.stat.rxEmpty);
		pollTxIdle();

		// hand-built frame, stop bit low
		rxSel = 1'b1;
		nextByte(b);
		fork
			sendFrame(b, 1'b0);
			waitRxFrames(1);
		join
		readReg(`regAddrStat, w);
		checkFlag("frame error rxEmpty", 1'b1, w.stat.rxEmpty);
		checkFlag("frame error flag", 1'b1, w.stat.frameErr);
		readReg(`regAddrStat, w);
		checkFlag("frame error cleared", 1'b0, w.stat.frameErr);
		rxSel = 1'b0;

		repeat (4) @(negedge clk);
		chkFails = DUT.chk.failCount;
		$display("errors: %0d testbench checks, %0d checker assertions", errCount, chkFails);
		if (errCount == 0 && chkFails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- src.f
+incdir+hw
hw/uartPkg.sv
hw/baudTickGen.sv
hw/uartFifo.sv
hw/uartTrans.sv
hw/uartRecv.sv
hw/uartRegs.sv
hw/uartTop.sv
verif/uart_checker.sv
verif/uartTb.sv
